//--- build.f
+incdir+design
design/img_bus_pkg.sv
design/img_op_pkg.sv
design/img_bus_if.sv
design/axi4s_to_img.sv
design/img_point_op.sv
design/img_to_axi4s.sv
design/img_stream_top.sv
test/tb_clock.sv
test/img_stream_tb.sv

//--- design/axi4s_to_img.sv
// ---------------------------------------------------------------------------
// AXI4-Stream video to image bus.
// tuser[0] starts a frame, tlast ends a line. Lines after line
// param_y_num-1 are blanked until the next frame start.
// s_axi4s_tready is the global clock enable; there is no buffering.
// ---------------------------------------------------------------------------

`include "img_params.svh"

`default_nettype none

module axi4s_to_img (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               cke,
    input  wire  img_bus_pkg::line_count_t    param_y_num,
    input  wire  [`IMG_USER_WIDTH:0]          s_axi4s_tuser,
    input  wire                               s_axi4s_tlast,
    input  wire  img_bus_pkg::pixel_t         s_axi4s_tdata,
    input  wire                               s_axi4s_tvalid,
    output logic                              s_axi4s_tready,
    img_bus_if.source                         img
);

    logic                      accept;
    logic                      cke_q;
    logic                      line_first_q;
    logic                      line_last_q;
    logic                      pixel_first_q;
    logic                      pixel_last_q;
    logic                      de_q;
    logic                      valid_q;
    img_bus_pkg::line_count_t  y_count;
    img_bus_pkg::line_count_t  y_next;
    img_bus_pkg::line_count_t  y_last;
    img_bus_pkg::user_t        user_q;
    img_bus_pkg::pixel_t       data_q;

    assign s_axi4s_tready = cke;
    assign accept         = s_axi4s_tvalid && cke;

    assign y_next = y_count + img_bus_pkg::line_count_t'(1);
    assign y_last = param_y_num - img_bus_pkg::line_count_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cke_q         <= 1'b0;
            line_first_q  <= 1'b0;
            line_last_q   <= 1'b0;
            pixel_first_q <= 1'b0;
            pixel_last_q  <= 1'b0;
            de_q          <= 1'b0;
            valid_q       <= 1'b0;
            y_count       <= '0;
        end else begin
            // Bus cke holds while stalled so the pulse is not lost.
            if (cke) begin
                cke_q <= s_axi4s_tvalid;
            end

            if (accept) begin
                pixel_first_q <= 1'b0;
                pixel_last_q  <= s_axi4s_tlast;

                // Previous beat closed a line.
                if (pixel_last_q) begin
                    line_first_q  <= 1'b0;
                    line_last_q   <= (y_next == y_last);
                    pixel_first_q <= 1'b1;
                    y_count       <= y_next;
                    if (line_last_q) begin
                        de_q <= 1'b0;
                    end
                end

                // Frame start overrides the line tracking.
                if (s_axi4s_tuser[0]) begin
                    line_first_q  <= 1'b1;
                    line_last_q   <= (param_y_num == img_bus_pkg::line_count_t'(1));
                    pixel_first_q <= 1'b1;
                    y_count       <= '0;
                    de_q          <= 1'b1;
                end
            end

            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            user_q <= s_axi4s_tuser[`IMG_USER_WIDTH:1];
            data_q <= s_axi4s_tdata;
        end
    end

    assign img.cke         = cke_q;
    assign img.line_first  = line_first_q;
    assign img.line_last   = line_last_q;
    assign img.pixel_first = pixel_first_q;
    assign img.pixel_last  = pixel_last_q;
    assign img.de          = de_q;
    assign img.user        = user_q;
    assign img.data        = data_q;
    assign img.valid       = valid_q;

endmodule

`default_nettype wire

//--- design/img_bus_if.sv
// ---------------------------------------------------------------------------
// Clock-enable driven image bus between stages.
// cke pulses once per accepted input beat. A sink samples only when
// both this cke and the global clock enable are high.
// ---------------------------------------------------------------------------

`default_nettype none

interface img_bus_if;

    logic                 cke;
    logic                 line_first;
    logic                 line_last;
    logic                 pixel_first;
    logic                 pixel_last;
    logic                 de;
    img_bus_pkg::user_t   user;
    img_bus_pkg::pixel_t  data;
    logic                 valid;

    modport source (
        output cke, line_first, line_last, pixel_first, pixel_last,
        output de, user, data, valid
    );

    modport sink (
        input  cke, line_first, line_last, pixel_first, pixel_last,
        input  de, user, data, valid
    );

endinterface

`default_nettype wire

//--- design/img_bus_pkg.sv
// ---------------------------------------------------------------------------
// Data types carried on the image bus.
// Sizes come from the shared parameter header.
// ---------------------------------------------------------------------------

`include "img_params.svh"

`default_nettype none

package img_bus_pkg;

    // One pixel.
    typedef logic [`IMG_DATA_WIDTH-1:0] pixel_t;

    // User side bits, without the frame-start bit.
    typedef logic [`IMG_USER_WIDTH-1:0] user_t;

    // Line index or line count.
    typedef logic [`IMG_Y_WIDTH-1:0] line_count_t;

endpackage

`default_nettype wire

//--- design/img_op_pkg.sv
// ---------------------------------------------------------------------------
// Point operation opcodes and the output FSM states.
// ---------------------------------------------------------------------------

`default_nettype none

package img_op_pkg;

    // Per-pixel operation select.
    typedef enum logic [1:0] {
        OP_PASS      = 2'd0,
        OP_INVERT    = 2'd1,
        OP_THRESHOLD = 2'd2,
        OP_BORDER    = 2'd3
    } point_op_t;

    // Output side blanking state.
    typedef enum logic {
        ST_BLANK  = 1'b0,
        ST_ACTIVE = 1'b1
    } out_state_t;

endpackage

`default_nettype wire

//--- design/img_params.svh
// ---------------------------------------------------------------------------
// Widths and default sizes of the video stream path.
// One pixel per beat. The line counter width limits param_y_num.
// ---------------------------------------------------------------------------

`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

`default_nettype none

// Pixel bits.
`define IMG_DATA_WIDTH      8
// User bits carried beside the frame-start bit.
`define IMG_USER_WIDTH      1
// Line counter bits.
`define IMG_Y_WIDTH         9
// Usual line count when param_y_num is left at its default (VGA height).
`define IMG_Y_NUM_DEFAULT   480

`default_nettype wire

`endif

//--- design/img_point_op.sv
// ---------------------------------------------------------------------------
// Per-pixel point operation, one registered stage.
// Flags pass through unchanged; only the data is modified.
// op and threshold are expected to be stable during a frame.
// ---------------------------------------------------------------------------

`default_nettype none

module img_point_op (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           cke,
    input  wire  img_op_pkg::point_op_t   op,
    input  wire  img_bus_pkg::pixel_t     threshold,
    img_bus_if.sink                       src,
    img_bus_if.source                     dst
);

    logic                 sample;
    logic                 border;
    img_bus_pkg::pixel_t  result;

    assign sample = src.cke && cke;
    assign border = src.line_first || src.line_last || src.pixel_first || src.pixel_last;

    always_comb begin
        case (op)
            img_op_pkg::OP_PASS:      result = src.data;
            img_op_pkg::OP_INVERT:    result = ~src.data;
            img_op_pkg::OP_THRESHOLD: result = (src.data >= threshold) ? '1 : '0;
            img_op_pkg::OP_BORDER:    result = border ? '1 : src.data;
            default:                  result = src.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dst.cke         <= 1'b0;
            dst.line_first  <= 1'b0;
            dst.line_last   <= 1'b0;
            dst.pixel_first <= 1'b0;
            dst.pixel_last  <= 1'b0;
            dst.de          <= 1'b0;
            dst.valid       <= 1'b0;
        end else if (cke) begin
            dst.cke <= src.cke;
            if (src.cke) begin
                dst.line_first  <= src.line_first;
                dst.line_last   <= src.line_last;
                dst.pixel_first <= src.pixel_first;
                dst.pixel_last  <= src.pixel_last;
                dst.de          <= src.de;
                dst.valid       <= src.valid;
            end
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        if (sample) begin
            dst.user <= src.user;
            dst.data <= result;
        end
    end

endmodule

`default_nettype wire

//--- design/img_stream_top.sv
// ---------------------------------------------------------------------------
// AXI4-Stream video path with one point operation.
// Latency is 3 enabled cycles. m_axi4s_tready is the clock enable of
// every stage and is returned as s_axi4s_tready.
// ---------------------------------------------------------------------------

`include "img_params.svh"

`default_nettype none

module img_stream_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [`IMG_USER_WIDTH:0]         s_axi4s_tuser,
    input  wire                              s_axi4s_tlast,
    input  wire  img_bus_pkg::pixel_t        s_axi4s_tdata,
    input  wire                              s_axi4s_tvalid,
    output logic                             s_axi4s_tready,
    output logic [`IMG_USER_WIDTH:0]         m_axi4s_tuser,
    output logic                             m_axi4s_tlast,
    output img_bus_pkg::pixel_t              m_axi4s_tdata,
    output logic                             m_axi4s_tvalid,
    input  wire                              m_axi4s_tready,
    input  wire  img_bus_pkg::line_count_t   param_y_num,
    input  wire  img_op_pkg::point_op_t      op,
    input  wire  img_bus_pkg::pixel_t        threshold
);

    img_bus_if raw ();
    img_bus_if processed ();

    axi4s_to_img axi4s_to_img_i (
        .clk            (clk),
        .reset          (reset),
        .cke            (m_axi4s_tready),
        .param_y_num    (param_y_num),
        .s_axi4s_tuser  (s_axi4s_tuser),
        .s_axi4s_tlast  (s_axi4s_tlast),
        .s_axi4s_tdata  (s_axi4s_tdata),
        .s_axi4s_tvalid (s_axi4s_tvalid),
        .s_axi4s_tready (s_axi4s_tready),
        .img            (raw.source)
    );

    img_point_op img_point_op_i (
        .clk       (clk),
        .reset     (reset),
        .cke       (m_axi4s_tready),
        .op        (op),
        .threshold (threshold),
        .src       (raw.sink),
        .dst       (processed.source)
    );

    img_to_axi4s img_to_axi4s_i (
        .clk            (clk),
        .reset          (reset),
        .cke            (m_axi4s_tready),
        .img            (processed.sink),
        .m_axi4s_tuser  (m_axi4s_tuser),
        .m_axi4s_tlast  (m_axi4s_tlast),
        .m_axi4s_tdata  (m_axi4s_tdata),
        .m_axi4s_tvalid (m_axi4s_tvalid)
    );

endmodule

`default_nettype wire

//--- design/img_to_axi4s.sv
// ---------------------------------------------------------------------------
// Image bus back to AXI4-Stream.
// Only pixels with de and valid set become output beats.
// tuser[0] marks the first pixel of the first line.
// The global cke must be m_axi4s_tready, or beats are repeated or lost.
// ---------------------------------------------------------------------------

`include "img_params.svh"

`default_nettype none

module img_to_axi4s (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          cke,
    img_bus_if.sink                      img,
    output logic [`IMG_USER_WIDTH:0]     m_axi4s_tuser,
    output logic                         m_axi4s_tlast,
    output img_bus_pkg::pixel_t          m_axi4s_tdata,
    output logic                         m_axi4s_tvalid
);

    img_op_pkg::out_state_t  state;
    img_op_pkg::out_state_t  state_next;
    logic                    sample;

    assign sample = img.cke && cke;

    always_comb begin
        state_next = state;
        case (state)
            img_op_pkg::ST_BLANK: begin
                if (img.de) begin
                    state_next = img_op_pkg::ST_ACTIVE;
                end
            end
            img_op_pkg::ST_ACTIVE: begin
                if (!img.de) begin
                    state_next = img_op_pkg::ST_BLANK;
                end
            end
            default: state_next = img_op_pkg::ST_BLANK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= img_op_pkg::ST_BLANK;
            m_axi4s_tvalid <= 1'b0;
        end else if (cke) begin
            if (img.cke) begin
                state          <= state_next;
                m_axi4s_tvalid <= (state_next == img_op_pkg::ST_ACTIVE) && img.valid;
            end else begin
                // Beat went out this cycle and nothing follows.
                m_axi4s_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            m_axi4s_tuser <= {img.user, img.line_first && img.pixel_first};
            m_axi4s_tlast <= img.pixel_last;
            m_axi4s_tdata <= img.data;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compiles the testbench with Verilator, runs it and checks the log.
# Run from the project root.

rm -f build.log sim.log

verilator --binary --timing -f build.f --top-module img_stream_tb -o img_stream_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/img_stream_sim > sim.log 2>&1 ; cat sim.log

grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- test/img_stream_tb.sv
// ---------------------------------------------------------------------------
// Testbench for the AXI4-Stream video path.
// Frames come from a stimulus table. Each accepted input beat is turned
// into an expected output beat and queued with its enabled-cycle stamp.
// op and threshold change only once all expected beats have left,
// since the point stage applies them while the beat passes through.
// ---------------------------------------------------------------------------

`include "img_params.svh"

`default_nettype none

module img_stream_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 9;
    localparam int LATENCY  = 3;

    typedef struct {
        img_op_pkg::point_op_t     op;
        img_bus_pkg::pixel_t       threshold;
        img_bus_pkg::line_count_t  y_num;
        int                        width;
        int                        lines;
        bit                        stall;
    } frame_row_t;

    logic                       clk;
    logic                       reset;
    logic [`IMG_USER_WIDTH:0]   s_axi4s_tuser;
    logic                       s_axi4s_tlast;
    img_bus_pkg::pixel_t        s_axi4s_tdata;
    logic                       s_axi4s_tvalid;
    logic                       s_axi4s_tready;
    logic [`IMG_USER_WIDTH:0]   m_axi4s_tuser;
    logic                       m_axi4s_tlast;
    img_bus_pkg::pixel_t        m_axi4s_tdata;
    logic                       m_axi4s_tvalid;
    logic                       m_axi4s_tready;
    img_bus_pkg::line_count_t   param_y_num;
    img_op_pkg::point_op_t      op;
    img_bus_pkg::pixel_t        threshold;

    frame_row_t                 rows [NUM_ROWS];
    img_bus_pkg::pixel_t        exp_data [$];
    logic [`IMG_USER_WIDTH:0]   exp_user [$];
    logic                       exp_last [$];
    int                         exp_stamp [$];

    int seed        = 32'hec4254a6;
    int en_count    = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    // Output beat was stalled on the previous edge.
    logic                       hold_pending = 1'b0;

    tb_clock tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    img_stream_top img_stream_top_i (
        .clk            (clk),
        .reset          (reset),
        .s_axi4s_tuser  (s_axi4s_tuser),
        .s_axi4s_tlast  (s_axi4s_tlast),
        .s_axi4s_tdata  (s_axi4s_tdata),
        .s_axi4s_tvalid (s_axi4s_tvalid),
        .s_axi4s_tready (s_axi4s_tready),
        .m_axi4s_tuser  (m_axi4s_tuser),
        .m_axi4s_tlast  (m_axi4s_tlast),
        .m_axi4s_tdata  (m_axi4s_tdata),
        .m_axi4s_tvalid (m_axi4s_tvalid),
        .m_axi4s_tready (m_axi4s_tready),
        .param_y_num    (param_y_num),
        .op             (op),
        .threshold      (threshold)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pixel(input string name, input img_bus_pkg::pixel_t got,
                               input img_bus_pkg::pixel_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_user(input string name, input logic [`IMG_USER_WIDTH:0] got,
                              input logic [`IMG_USER_WIDTH:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %0d cycles, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    // Result of one pixel under the selected operation.
    function automatic img_bus_pkg::pixel_t expected_pixel(
        input img_op_pkg::point_op_t code, input img_bus_pkg::pixel_t thr,
        input img_bus_pkg::pixel_t pix, input bit on_border);
        img_bus_pkg::pixel_t ones;
        ones = '1;
        if (code == img_op_pkg::OP_INVERT) begin
            return ones ^ pix;
        end else if (code == img_op_pkg::OP_THRESHOLD) begin
            return (pix < thr) ? img_bus_pkg::pixel_t'(0) : ones;
        end else if (code == img_op_pkg::OP_BORDER && on_border) begin
            return ones;
        end
        return pix;
    endfunction

    task automatic load_rows();
        rows[0] = '{img_op_pkg::OP_PASS,      8'd0,   9'd3, 4, 3, 1'b0};
        rows[1] = '{img_op_pkg::OP_INVERT,    8'd0,   9'd4, 5, 4, 1'b0};
        rows[2] = '{img_op_pkg::OP_THRESHOLD, 8'd128, 9'd4, 5, 4, 1'b0};
        rows[3] = '{img_op_pkg::OP_BORDER,    8'd0,   9'd5, 6, 5, 1'b0};
        // Two lines past the programmed count.
        rows[4] = '{img_op_pkg::OP_BORDER,    8'd0,   9'd3, 6, 5, 1'b0};
        rows[5] = '{img_op_pkg::OP_PASS,      8'd0,   9'd4, 5, 6, 1'b1};
        rows[6] = '{img_op_pkg::OP_THRESHOLD, 8'd90,  9'd3, 4, 3, 1'b1};
        rows[7] = '{img_op_pkg::OP_THRESHOLD, 8'd90,  9'd2, 3, 4, 1'b0};
        rows[8] = '{img_op_pkg::OP_INVERT,    8'd0,   9'd1, 4, 2, 1'b1};
    endtask

    task automatic drive_tready(input bit stall);
        if (stall) begin
            m_axi4s_tready <= (($random(seed) & 3) != 0);
        end else begin
            m_axi4s_tready <= 1'b1;
        end
    endtask

    // Holds one beat until it transfers; stamp is the enabled-edge count.
    task automatic send_beat(input img_bus_pkg::pixel_t data, input img_bus_pkg::user_t user,
                             input logic sof, input logic last, input bit stall,
                             output int stamp);
        logic accepted;
        s_axi4s_tdata  <= data;
        s_axi4s_tuser  <= {user, sof};
        s_axi4s_tlast  <= last;
        s_axi4s_tvalid <= 1'b1;
        accepted = 1'b0;
        stamp = 0;
        while (!accepted) begin
            @(posedge clk);
            accepted = s_axi4s_tready;
            stamp = en_count;
            drive_tready(stall);
        end
    endtask

    task automatic send_frame(input frame_row_t row);
        img_bus_pkg::pixel_t  data;
        img_bus_pkg::user_t   user;
        logic                 sof;
        logic                 last;
        bit                   on_border;
        int                   stamp;
        for (int y = 0; y < row.lines; y++) begin
            for (int x = 0; x < row.width; x++) begin
                data = img_bus_pkg::pixel_t'($random(seed));
                user = img_bus_pkg::user_t'($random(seed));
                sof  = (y == 0) && (x == 0);
                last = (x == row.width - 1);
                send_beat(data, user, sof, last, row.stall, stamp);
                // Lines past the count are blanked and give no beat.
                if (y < int'(row.y_num)) begin
                    on_border = (y == 0) || (y == int'(row.y_num) - 1) || (x == 0) || last;
                    exp_data.push_back(expected_pixel(row.op, row.threshold, data, on_border));
                    exp_user.push_back({user, sof});
                    exp_last.push_back(last);
                    exp_stamp.push_back(stamp);
                end
            end
        end
    endtask

    task automatic drain(input bit stall);
        while (exp_data.size() != 0) begin
            @(posedge clk);
            drive_tready(stall);
        end
    endtask

    // Output monitor, latency count and timeout.
    always @(posedge clk) begin
        if (reset) begin
            en_count     <= 0;
            hold_pending = 1'b0;
        end else begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                stop_with_failure($sformatf("timeout: no finish within %0d cycles", cycle_limit));
            end
            if (m_axi4s_tready) begin
                en_count <= en_count + 1;
            end
            check_flag("s_axi4s_tready", s_axi4s_tready, m_axi4s_tready);
            // A stalled beat stays on the output until it transfers.
            if (hold_pending) begin
                check_flag("m_axi4s_tvalid", m_axi4s_tvalid, 1'b1);
            end
            if (m_axi4s_tvalid) begin
                if (exp_data.size() == 0) begin
                    stop_with_failure("output beat seen with no expected beat left");
                end else begin
                    check_pixel("m_axi4s_tdata", m_axi4s_tdata, exp_data[0]);
                    check_user("m_axi4s_tuser", m_axi4s_tuser, exp_user[0]);
                    check_flag("m_axi4s_tlast", m_axi4s_tlast, exp_last[0]);
                    if (m_axi4s_tready) begin
                        check_latency("latency", en_count - exp_stamp[0], LATENCY);
                        void'(exp_data.pop_front());
                        void'(exp_user.pop_front());
                        void'(exp_last.pop_front());
                        void'(exp_stamp.pop_front());
                    end
                end
            end
            hold_pending = m_axi4s_tvalid && !m_axi4s_tready;
        end
    end

    initial begin
        int total_beats;
        s_axi4s_tuser  <= '0;
        s_axi4s_tlast  <= 1'b0;
        s_axi4s_tdata  <= '0;
        s_axi4s_tvalid <= 1'b0;
        m_axi4s_tready <= 1'b1;
        param_y_num    <= 9'd1;
        op             <= img_op_pkg::OP_PASS;
        threshold      <= '0;
        load_rows();
        total_beats = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_beats += rows[r].width * rows[r].lines;
        end
        cycle_limit = 2 * total_beats + 200;

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r > 0 && (rows[r].op != rows[r - 1].op ||
                          rows[r].threshold != rows[r - 1].threshold)) begin
                s_axi4s_tvalid <= 1'b0;
                drain(rows[r - 1].stall);
            end
            op          <= rows[r].op;
            threshold   <= rows[r].threshold;
            param_y_num <= rows[r].y_num;
            send_frame(rows[r]);
        end

        // Let the pipeline empty, then watch for stray beats.
        s_axi4s_tvalid <= 1'b0;
        m_axi4s_tready <= 1'b1;
        for (int i = 0; i < 40 && exp_data.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);

        if (exp_data.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d expected output beats never arrived",
                                        exp_data.size()));
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// ---------------------------------------------------------------------------
// Testbench clock and reset.
// 4 ns clock period. Reset is high for the first 3 rising edges and
// is released with a non-blocking assignment on the third one.
// ---------------------------------------------------------------------------

`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
